// File: rtl/uart_dbg_pkg.sv
// Protocol byte codes, byte and field types, channel struct and engine states
package uart_dbg_pkg;

  ////////////////////
  // Widths
  ////////////////////

  // One serial data byte
  typedef logic [7:0]  byte_t;
  // Address or length field of a command
  typedef logic [63:0] field_t;

  ////////////////////
  // Protocol codes
  ////////////////////

  localparam byte_t CMD_READ  = 8'h11;
  localparam byte_t CMD_WRITE = 8'h12;
  localparam byte_t CODE_ACK  = 8'h06;
  localparam byte_t CODE_EOT  = 8'h04;

  // Bytes per address or length field, sent LSB first
  localparam int unsigned FIELD_BYTES = 8;

  // Byte channel, data travels with req
  typedef struct packed {
    logic  req;
    byte_t data;
  } byte_req_t;

  // Command engine states
  typedef enum logic [2:0] {
    IDLE,
    GET_ADDR,
    GET_LEN,
    SEND_ACK,
    MOVE_DATA,
    SEND_EOT,
    REPLY_ACK
  } engine_state_e;

endpackage

// File: rtl/uart_byte_rx.sv
// UART byte receiver with baud oversampling, parity check and req/ack byte output
`timescale 1ns/1ps

module uart_byte_rx #(
  parameter int unsigned CLKS_PER_BIT = 8,
  parameter bit          PARITY_EN    = 1'b1
) (
  input  logic                    clk,
  input  logic                    rst_n_i,
  input  logic                    rx_i,
  output uart_dbg_pkg::byte_req_t chan_o,
  input  logic                    ack_i,
  output logic                    parity_err_o
);

  import uart_dbg_pkg::*;

  localparam int unsigned CNT_W = $clog2(CLKS_PER_BIT + 1);
  typedef logic [CNT_W-1:0] baud_cnt_t;
  localparam baud_cnt_t HALF_CNT = baud_cnt_t'(CLKS_PER_BIT / 2 - 1);
  localparam baud_cnt_t FULL_CNT = baud_cnt_t'(CLKS_PER_BIT - 1);

  typedef enum logic [2:0] {
    RX_IDLE,
    RX_START,
    RX_DATA,
    RX_PARITY,
    RX_STOP
  } rx_state_e;

  rx_state_e  state_q;
  baud_cnt_t  cnt_q;
  logic [2:0] bit_idx_q;
  byte_t      shift_q;
  logic       par_q;
  logic       rx_meta_q;
  logic       rx_s_q;
  logic       req_q;
  byte_t      out_q;
  logic       hold_q;
  byte_t      hold_data_q;
  logic       perr_q;
  logic       tick;
  logic       par_ok;
  logic       byte_done;
  logic       par_fail;
  logic       chan_free;
  logic       drain;
  logic       direct;
  logic       load_hold;
  logic       overrun;

  // Two-flop synchronizer, line idles high
  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      rx_meta_q <= 1'b1;
      rx_s_q    <= 1'b1;
    end else begin
      rx_meta_q <= rx_i;
      rx_s_q    <= rx_meta_q;
    end
  end

  ////////////////////
  // Bit sampling
  ////////////////////

  // Start bit is checked at half period, all later bits at mid-bit
  assign tick = (state_q == RX_START) ? (cnt_q == HALF_CNT) : (cnt_q == FULL_CNT);

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      state_q   <= RX_IDLE;
      cnt_q     <= '0;
      bit_idx_q <= '0;
    end else begin
      cnt_q <= (state_q == RX_IDLE || tick) ? '0 : cnt_q + 1'b1;
      case (state_q)
        RX_IDLE: if (!rx_s_q) state_q <= RX_START;
        RX_START: begin
          if (tick) begin
            bit_idx_q <= '0;
            // Glitch shorter than half a bit is ignored
            state_q   <= rx_s_q ? RX_IDLE : RX_DATA;
          end
        end
        RX_DATA: begin
          if (tick) begin
            bit_idx_q <= bit_idx_q + 1'b1;
            if (bit_idx_q == 3'd7) state_q <= PARITY_EN ? RX_PARITY : RX_STOP;
          end
        end
        RX_PARITY: if (tick) state_q <= RX_STOP;
        RX_STOP: if (tick) state_q <= RX_IDLE;
        default: state_q <= RX_IDLE;
      endcase
    end
  end

  // LSB arrives first
  always_ff @(posedge clk) begin
    if (state_q == RX_DATA && tick) shift_q <= {rx_s_q, shift_q[7:1]};
    if (state_q == RX_PARITY && tick) par_q <= rx_s_q;
  end

  // Even parity: parity bit equals XOR of data bits
  assign par_ok    = !PARITY_EN || (par_q == ^shift_q);
  assign byte_done = (state_q == RX_STOP) && tick && rx_s_q && par_ok;
  assign par_fail  = (state_q == RX_STOP) && tick && !par_ok;

  ////////////////////
  // Output buffer
  ////////////////////

  assign chan_free = !req_q && !ack_i;
  assign drain     = chan_free && hold_q;
  assign direct    = byte_done && chan_free && !hold_q;
  assign load_hold = byte_done && (hold_q ? chan_free : !chan_free);
  assign overrun   = byte_done && hold_q && !chan_free;

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      req_q  <= 1'b0;
      hold_q <= 1'b0;
      perr_q <= 1'b0;
    end else begin
      if (req_q && ack_i) req_q <= 1'b0;
      else if (drain || direct) req_q <= 1'b1;
      if (load_hold) hold_q <= 1'b1;
      else if (drain) hold_q <= 1'b0;
      // Sticky until reset
      if (par_fail) perr_q <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (drain) out_q <= hold_data_q;
    else if (direct) out_q <= shift_q;
    if (load_hold) hold_data_q <= shift_q;
  end

  assign chan_o       = '{req: req_q, data: out_q};
  assign parity_err_o = perr_q;

  // Four-phase rule, req only falls after ack
  a_req_fall: assert property (@(posedge clk) disable iff (!rst_n_i)
    $fell(req_q) |-> $past(ack_i));

  // Sender spacing must leave room in the single buffer
  a_no_overrun: assert property (@(posedge clk) disable iff (!rst_n_i) !overrun);

endmodule

// File: rtl/uart_byte_tx.sv
// UART byte transmitter framing one byte per req/ack transfer
`timescale 1ns/1ps

module uart_byte_tx #(
  parameter int unsigned CLKS_PER_BIT = 8,
  parameter bit          PARITY_EN    = 1'b1
) (
  input  logic                    clk,
  input  logic                    rst_n_i,
  input  uart_dbg_pkg::byte_req_t chan_i,
  output logic                    ack_o,
  output logic                    tx_o
);

  import uart_dbg_pkg::*;

  localparam int unsigned CNT_W = $clog2(CLKS_PER_BIT + 1);
  typedef logic [CNT_W-1:0] baud_cnt_t;
  localparam baud_cnt_t FULL_CNT = baud_cnt_t'(CLKS_PER_BIT - 1);

  typedef enum logic [2:0] {
    TX_IDLE,
    TX_START,
    TX_DATA,
    TX_PARITY,
    TX_STOP
  } tx_state_e;

  tx_state_e  state_q;
  baud_cnt_t  cnt_q;
  logic [2:0] bit_idx_q;
  byte_t      shift_q;
  logic       par_q;
  logic       tx_q;
  logic       ack_q;
  logic       tick;
  logic       latch;

  assign tick  = (cnt_q == FULL_CNT);
  // New byte only between frames and after the previous transfer closed
  assign latch = (state_q == TX_IDLE) && chan_i.req && !ack_q;

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      state_q   <= TX_IDLE;
      cnt_q     <= '0;
      bit_idx_q <= '0;
      tx_q      <= 1'b1;
      ack_q     <= 1'b0;
    end else begin
      cnt_q <= (state_q == TX_IDLE || tick) ? '0 : cnt_q + 1'b1;
      if (latch) ack_q <= 1'b1;
      else if (ack_q && !chan_i.req) ack_q <= 1'b0;
      case (state_q)
        TX_IDLE: begin
          tx_q <= 1'b1;
          if (latch) begin
            tx_q    <= 1'b0;
            state_q <= TX_START;
          end
        end
        TX_START: begin
          if (tick) begin
            tx_q      <= shift_q[0];
            bit_idx_q <= '0;
            state_q   <= TX_DATA;
          end
        end
        TX_DATA: begin
          if (tick) begin
            bit_idx_q <= bit_idx_q + 1'b1;
            if (bit_idx_q != 3'd7) begin
              tx_q <= shift_q[1];
            end else if (PARITY_EN) begin
              tx_q    <= par_q;
              state_q <= TX_PARITY;
            end else begin
              tx_q    <= 1'b1;
              state_q <= TX_STOP;
            end
          end
        end
        TX_PARITY: begin
          if (tick) begin
            tx_q    <= 1'b1;
            state_q <= TX_STOP;
          end
        end
        TX_STOP: if (tick) state_q <= TX_IDLE;
        default: state_q <= TX_IDLE;
      endcase
    end
  end

  // Shift register moves right after each data bit
  always_ff @(posedge clk) begin
    if (latch) begin
      shift_q <= chan_i.data;
      par_q   <= ^chan_i.data;
    end else if (state_q == TX_DATA && tick) begin
      shift_q <= {1'b0, shift_q[7:1]};
    end
  end

  assign ack_o = ack_q;
  assign tx_o  = tx_q;

  // Sender keeps data steady for the whole req/ack overlap
  a_data_stable: assert property (@(posedge clk) disable iff (!rst_n_i)
    (chan_i.req && ack_o) |=> (!(chan_i.req && ack_o) || $stable(chan_i.data)));

endmodule

// File: rtl/uart_dbg_engine.sv
// Debug command engine with parser, byte memory and reply sequencer
`timescale 1ns/1ps

module uart_dbg_engine #(
  parameter int unsigned MEM_DEPTH = 64
) (
  input  logic                    clk,
  input  logic                    rst_n_i,
  input  uart_dbg_pkg::byte_req_t rx_chan_i,
  output logic                    rx_ack_o,
  output uart_dbg_pkg::byte_req_t tx_chan_o,
  input  logic                    tx_ack_i
);

  import uart_dbg_pkg::*;

  localparam int unsigned AW    = $clog2(MEM_DEPTH);
  localparam int unsigned IDX_W = $clog2(FIELD_BYTES);
  typedef logic [AW-1:0]    mem_addr_t;
  typedef logic [IDX_W-1:0] field_idx_t;

  engine_state_e state_q;
  logic          is_read_q;
  field_idx_t    idx_q;
  field_t        field_q;
  field_t        len_q;
  mem_addr_t     addr_q;
  logic          rx_ack_q;
  logic          tx_req_q;
  byte_t         tx_data_q;
  byte_t         mem_q [MEM_DEPTH];

  logic   rx_take;
  field_t field_next;
  logic   field_last;
  logic   sending;
  logic   tx_free;
  logic   tx_raise;
  logic   tx_done;
  logic   mem_we;
  logic   step;
  byte_t  tx_byte;

  ////////////////////
  // Channel control
  ////////////////////

  // Every byte is taken, unexpected ones are simply dropped
  assign rx_take = rx_chan_i.req && !rx_ack_q;

  assign sending  = (state_q == SEND_ACK) || (state_q == SEND_EOT) ||
                    (state_q == REPLY_ACK) || (state_q == MOVE_DATA && is_read_q);
  assign tx_free  = !tx_req_q && !tx_ack_i;
  assign tx_raise = sending && tx_free;
  assign tx_done  = tx_req_q && tx_ack_i;

  // Fields come LSB first, so shift in from the top
  assign field_next = {rx_chan_i.data, field_q[$bits(field_t)-1:8]};
  assign field_last = (idx_q == field_idx_t'(FIELD_BYTES - 1));

  // One data byte moved, paced by tx for reads and by rx for writes
  assign step   = (state_q == MOVE_DATA) && (is_read_q ? tx_done : rx_take);
  assign mem_we = (state_q == MOVE_DATA) && !is_read_q && rx_take;

  always_comb begin
    case (state_q)
      MOVE_DATA: tx_byte = mem_q[addr_q];
      SEND_EOT:  tx_byte = CODE_EOT;
      default:   tx_byte = CODE_ACK;
    endcase
  end

  ////////////////////
  // Command FSM
  ////////////////////

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      state_q   <= IDLE;
      is_read_q <= 1'b0;
      idx_q     <= '0;
      len_q     <= '0;
      addr_q    <= '0;
      rx_ack_q  <= 1'b0;
      tx_req_q  <= 1'b0;
    end else begin
      if (rx_take) rx_ack_q <= 1'b1;
      else if (rx_ack_q && !rx_chan_i.req) rx_ack_q <= 1'b0;
      if (tx_done) tx_req_q <= 1'b0;
      else if (tx_raise) tx_req_q <= 1'b1;

      case (state_q)
        IDLE: begin
          idx_q <= '0;
          if (rx_take) begin
            case (rx_chan_i.data)
              CODE_ACK: state_q <= REPLY_ACK;
              CMD_READ: begin
                is_read_q <= 1'b1;
                state_q   <= GET_ADDR;
              end
              CMD_WRITE: begin
                is_read_q <= 1'b0;
                state_q   <= GET_ADDR;
              end
              default: state_q <= IDLE;
            endcase
          end
        end
        GET_ADDR: begin
          if (rx_take) begin
            idx_q <= idx_q + 1'b1;
            if (field_last) begin
              // Only the low bits reach the memory, accesses wrap
              addr_q  <= field_next[AW-1:0];
              state_q <= GET_LEN;
            end
          end
        end
        GET_LEN: begin
          if (rx_take) begin
            idx_q <= idx_q + 1'b1;
            if (field_last) begin
              len_q   <= field_next;
              state_q <= SEND_ACK;
            end
          end
        end
        SEND_ACK: if (tx_done) state_q <= (len_q == '0) ? SEND_EOT : MOVE_DATA;
        MOVE_DATA: begin
          if (step) begin
            addr_q <= addr_q + 1'b1;
            len_q  <= len_q - 1'b1;
            if (len_q == field_t'(1)) state_q <= SEND_EOT;
          end
        end
        SEND_EOT, REPLY_ACK: if (tx_done) state_q <= IDLE;
        default: state_q <= IDLE;
      endcase
    end
  end

  ////////////////////
  // Data path
  ////////////////////

  always_ff @(posedge clk) begin
    if (rx_take && (state_q == GET_ADDR || state_q == GET_LEN)) field_q <= field_next;
    if (tx_raise) tx_data_q <= tx_byte;
  end

  // Byte memory
  always_ff @(posedge clk) begin
    if (mem_we) mem_q[addr_q] <= rx_chan_i.data;
  end

  assign rx_ack_o  = rx_ack_q;
  assign tx_chan_o = '{req: tx_req_q, data: tx_data_q};

  a_state_legal: assert property (@(posedge clk) disable iff (!rst_n_i)
    state_q inside {IDLE, GET_ADDR, GET_LEN, SEND_ACK, MOVE_DATA, SEND_EOT, REPLY_ACK});

  // Transmitter must have closed the previous transfer first
  a_tx_req_rise: assert property (@(posedge clk) disable iff (!rst_n_i)
    $rose(tx_req_q) |-> !$past(tx_ack_i));

endmodule

// File: rtl/uart_dbg_top.sv
// UART debug server top level with receiver, transmitter and command engine
`timescale 1ns/1ps

module uart_dbg_top #(
  parameter int unsigned CLKS_PER_BIT = 8,
  parameter bit          PARITY_EN    = 1'b1,
  parameter int unsigned MEM_DEPTH    = 64
) (
  input  logic clk,
  input  logic rst_n_i,
  input  logic uart_rx_i,
  output logic uart_tx_o,
  output logic parity_err_o
);

  import uart_dbg_pkg::*;

  byte_req_t rx_chan;
  logic      rx_ack;
  byte_req_t tx_chan;
  logic      tx_ack;

  ////////////////////
  // Serial side
  ////////////////////

  uart_byte_rx #(
    .CLKS_PER_BIT (CLKS_PER_BIT),
    .PARITY_EN    (PARITY_EN)
  ) uart_byte_rx_i (
    .clk          (clk),
    .rst_n_i      (rst_n_i),
    .rx_i         (uart_rx_i),
    .chan_o       (rx_chan),
    .ack_i        (rx_ack),
    .parity_err_o (parity_err_o)
  );

  uart_byte_tx #(
    .CLKS_PER_BIT (CLKS_PER_BIT),
    .PARITY_EN    (PARITY_EN)
  ) uart_byte_tx_i (
    .clk     (clk),
    .rst_n_i (rst_n_i),
    .chan_i  (tx_chan),
    .ack_o   (tx_ack),
    .tx_o    (uart_tx_o)
  );

  // Command handling and memory
  uart_dbg_engine #(
    .MEM_DEPTH (MEM_DEPTH)
  ) uart_dbg_engine_i (
    .clk       (clk),
    .rst_n_i   (rst_n_i),
    .rx_chan_i (rx_chan),
    .rx_ack_o  (rx_ack),
    .tx_chan_o (tx_chan),
    .tx_ack_i  (tx_ack)
  );

endmodule

// File: bench/tb_clk_gen.sv
// Bench clock and synchronous reset generator
`timescale 1ns/1ps

module tb_clk_gen #(
  parameter int PERIOD_NS  = 100,
  parameter int RST_CYCLES = 5
) (
  output logic clk,
  output logic rst_n_o
);

  initial begin
    clk = 1'b0;
    forever #(PERIOD_NS / 2) clk = ~clk;
  end

  // Reset held low for a few edges, released just after one
  initial begin
    rst_n_o = 1'b0;
    repeat (RST_CYCLES) @(posedge clk);
    #1 rst_n_o = 1'b1;
  end

endmodule

// File: bench/tb_uart_dbg.sv
// Bench top with serial driver, reply monitor, LFSR, reference model, checks and report
`timescale 1ns/1ps

module tb_uart_dbg;

  localparam int CLKS_PER_BIT = 8;
  localparam bit PARITY_EN    = 1'b1;
  localparam int MEM_DEPTH    = 64;

  localparam logic [7:0] ACK = 8'h06;
  localparam logic [7:0] EOT = 8'h04;
  localparam logic [7:0] RD  = 8'h11;
  localparam logic [7:0] WR  = 8'h12;

  // One frame is start, 8 data, parity and stop
  localparam int unsigned FRAME_CYCLES = 11 * CLKS_PER_BIT;
  localparam int unsigned REPLY_LIMIT  = 40 * FRAME_CYCLES;
  localparam int unsigned QUIET_CYCLES = 4 * FRAME_CYCLES;
  localparam int unsigned START_LIMIT  = 2 * FRAME_CYCLES;

  logic clk;
  logic rst_n;
  logic uart_rx_i;
  logic uart_tx_o;
  logic parity_err_o;

  logic [7:0]  exp_q [$];
  logic [7:0]  wr_data_q [$];
  logic [7:0]  shadow_mem [MEM_DEPTH];
  logic [31:0] lfsr_q;
  logic        rx_busy = 1'b0;
  int unsigned err_cnt = 0;
  int unsigned err_base = 0;
  int unsigned test_cnt = 0;
  int unsigned fail_cnt = 0;

  tb_clk_gen #(
    .PERIOD_NS  (100),
    .RST_CYCLES (5)
  ) tb_clk_gen_i (
    .clk     (clk),
    .rst_n_o (rst_n)
  );

  uart_dbg_top #(
    .CLKS_PER_BIT (CLKS_PER_BIT),
    .PARITY_EN    (PARITY_EN),
    .MEM_DEPTH    (MEM_DEPTH)
  ) uart_dbg_top_i (
    .clk          (clk),
    .rst_n_i      (rst_n),
    .uart_rx_i    (uart_rx_i),
    .uart_tx_o    (uart_tx_o),
    .parity_err_o (parity_err_o)
  );

  ////////////////////
  // Random source
  ////////////////////

  // Fibonacci LFSR with taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  function automatic logic [7:0] rand_byte();
    logic [7:0] b;
    for (int i = 0; i < 8; i++) begin
      lfsr_q = lfsr_next(lfsr_q);
      b[i] = lfsr_q[0];
    end
    return b;
  endfunction

  function automatic logic [63:0] rand_field();
    logic [63:0] f;
    for (int i = 0; i < 8; i++) f[8*i +: 8] = rand_byte();
    return f;
  endfunction

  ////////////////////
  // Reference model
  ////////////////////

  // Expected reply bytes of one command
  // Shadow memory wraps like the target
  function automatic void ref_model(input logic [7:0] cmd, input logic [63:0] addr,
                                    input logic [63:0] len);
    int a;
    a = int'(addr % MEM_DEPTH);
    if (cmd == ACK) begin
      exp_q.push_back(ACK);
    end else if (cmd == RD || cmd == WR) begin
      exp_q.push_back(ACK);
      for (int i = 0; i < int'(len); i++) begin
        if (cmd == WR) shadow_mem[a] = wr_data_q[i];
        else exp_q.push_back(shadow_mem[a]);
        a = (a + 1) % MEM_DEPTH;
      end
      exp_q.push_back(EOT);
    end
  endfunction

  ////////////////////
  // Serial driver
  ////////////////////

  task automatic drive_bit(input logic b);
    @(posedge clk);
    #1 uart_rx_i = b;
    repeat (CLKS_PER_BIT - 1) @(posedge clk);
  endtask

  // Even parity, then stop bit and two idle bit periods
  task automatic send_byte(input logic [7:0] data, input logic bad_parity);
    drive_bit(1'b0);
    for (int i = 0; i < 8; i++) drive_bit(data[i]);
    drive_bit(^data ^ bad_parity);
    drive_bit(1'b1);
    drive_bit(1'b1);
    drive_bit(1'b1);
  endtask

  task automatic send_cmd(input logic [7:0] cmd, input logic [63:0] addr,
                          input logic [63:0] len);
    send_byte(cmd, 1'b0);
    for (int i = 0; i < 8; i++) send_byte(addr[8*i +: 8], 1'b0);
    for (int i = 0; i < 8; i++) send_byte(len[8*i +: 8], 1'b0);
  endtask

  ////////////////////
  // Reply monitor
  ////////////////////

  // Samples at falling edges and at mid-bit once the start edge is found
  task automatic receive_byte(output logic found, output logic [7:0] data);
    int unsigned waited;
    logic        par;
    found = 1'b0;
    data = '0;
    waited = 0;
    do begin
      @(negedge clk);
      waited++;
    end while (!(rst_n && uart_tx_o == 1'b0) && waited < START_LIMIT);
    if (rst_n && uart_tx_o == 1'b0) begin
      rx_busy = 1'b1;
      repeat (CLKS_PER_BIT / 2) @(negedge clk);
      assert (uart_tx_o == 1'b0) else begin
        $display("ERR uart_tx_o: start bit got %h, expected 0", uart_tx_o);
        err_cnt++;
      end
      for (int i = 0; i < 8; i++) begin
        repeat (CLKS_PER_BIT) @(negedge clk);
        data[i] = uart_tx_o;
      end
      repeat (CLKS_PER_BIT) @(negedge clk);
      par = uart_tx_o;
      assert (par == ^data) else begin
        $display("ERR uart_tx_o: parity bit of byte %02h got %h, expected %h",
                 data, par, ^data);
        err_cnt++;
      end
      repeat (CLKS_PER_BIT) @(negedge clk);
      assert (uart_tx_o == 1'b1) else begin
        $display("ERR uart_tx_o: stop bit got %h, expected 1", uart_tx_o);
        err_cnt++;
      end
      found = 1'b1;
    end
  endtask

  function automatic void compare_byte(input logic [7:0] got);
    logic [7:0] want;
    assert (exp_q.size() != 0) else begin
      $display("Reply byte %02h arrived when none was expected", got);
      err_cnt++;
    end
    if (exp_q.size() != 0) begin
      want = exp_q.pop_front();
      assert (got == want) else begin
        $display("ERR uart_tx_o: got %02h, expected %02h", got, want);
        err_cnt++;
      end
    end
  endfunction

  initial begin : monitor
    logic       found;
    logic [7:0] data;
    forever begin
      receive_byte(found, data);
      if (found) compare_byte(data);
      rx_busy = 1'b0;
    end
  end

  ////////////////////
  // Test steps
  ////////////////////

  task automatic wait_reply();
    int unsigned n;
    n = 0;
    while ((exp_q.size() != 0 || rx_busy) && n < REPLY_LIMIT) begin
      @(posedge clk);
      n++;
    end
    assert (exp_q.size() == 0 && !rx_busy) else begin
      $display("Timeout with %0d reply bytes still missing", exp_q.size());
      err_cnt++;
      exp_q.delete();
    end
    // Stray bytes show up as unexpected in this window
    repeat (QUIET_CYCLES) @(posedge clk);
    n = 0;
    while (rx_busy && n < FRAME_CYCLES) begin
      @(posedge clk);
      n++;
    end
  endtask

  task automatic do_write(input logic [63:0] addr, input int unsigned len);
    wr_data_q.delete();
    for (int unsigned i = 0; i < len; i++) wr_data_q.push_back(rand_byte());
    ref_model(WR, addr, 64'(len));
    send_cmd(WR, addr, 64'(len));
    foreach (wr_data_q[i]) send_byte(wr_data_q[i], 1'b0);
    wait_reply();
  endtask

  task automatic do_read(input logic [63:0] addr, input int unsigned len);
    ref_model(RD, addr, 64'(len));
    send_cmd(RD, addr, 64'(len));
    wait_reply();
  endtask

  task automatic challenge();
    ref_model(ACK, '0, '0);
    send_byte(ACK, 1'b0);
    wait_reply();
  endtask

  task automatic end_test(input string name);
    test_cnt++;
    if (err_cnt == err_base) begin
      $display("test %0d %s: pass", test_cnt, name);
    end else begin
      fail_cnt++;
      $display("test %0d %s: fail", test_cnt, name);
    end
    err_base = err_cnt;
  endtask

  initial begin : main
    int unsigned n;
    logic [63:0] addr;
    uart_rx_i = 1'b1;
    lfsr_q = 32'd92990;
    n = 0;
    while (!rst_n && n < 100) begin
      @(posedge clk);
      n++;
    end
    assert (rst_n) else begin
      $display("Reset was never released");
      err_cnt++;
    end

    // Idle line and clear flag after reset before a challenge
    repeat (16) begin
      @(negedge clk);
      assert (uart_tx_o == 1'b1) else begin
        $display("ERR uart_tx_o: got %h, expected 1", uart_tx_o);
        err_cnt++;
      end
      assert (parity_err_o == 1'b0) else begin
        $display("ERR parity_err_o: got %h, expected 0", parity_err_o);
        err_cnt++;
      end
    end
    challenge();
    end_test("reset and challenge");

    addr = rand_field();
    do_write(addr, 16);
    do_read(addr, 16);
    end_test("write then read back");

    // Start five bytes below the top so the write wraps
    addr = (rand_field() & ~64'(MEM_DEPTH - 1)) | 64'(MEM_DEPTH - 5);
    do_write(addr, 12);
    do_read(rand_field() & ~64'(MEM_DEPTH - 1), 7);
    end_test("wrap at memory end");

    ref_model(8'h55, '0, '0);
    send_byte(8'h55, 1'b0);
    wait_reply();
    challenge();
    end_test("unknown byte ignored");

    do_read(rand_field(), 0);
    end_test("zero length read");

    send_byte(ACK, 1'b1);
    n = 0;
    while (!parity_err_o && n < FRAME_CYCLES) begin
      @(negedge clk);
      n++;
    end
    assert (parity_err_o == 1'b1) else begin
      $display("ERR parity_err_o: got %h, expected 1", parity_err_o);
      err_cnt++;
    end
    wait_reply();
    challenge();
    end_test("parity error");

    $display("%0d tests, %0d failed, %0d errors", test_cnt, fail_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

// File: verilog.f
rtl/uart_dbg_pkg.sv
rtl/uart_byte_rx.sv
rtl/uart_byte_tx.sv
rtl/uart_dbg_engine.sv
rtl/uart_dbg_top.sv
bench/tb_clk_gen.sv
bench/tb_uart_dbg.sv

// File: run.sh
#!/usr/bin/env bash
# Build the bench with Verilator, run it, then look for the fail message in the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log
verilator --binary --timing --assert -j 0 --top-module tb_uart_dbg \
  -f verilog.f -o tb_uart_dbg > build.log 2>&1 &&
  ./obj_dir/tb_uart_dbg > sim.log 2>&1 ||
  { cat build.log sim.log 2> /dev/null; echo "Build or simulation did not complete"; exit 1; }
cat sim.log
grep -q "TESTS FAILED" sim.log && exit 1 || exit 0
